// ==== uart_pkg.sv ====
//--------------------------------------------------------------------------
// shared types, register addresses and bit positions of the uart block
// imported by wildcard into every module that needs them
//--------------------------------------------------------------------------
package uart_pkg;

    // data types ------------------------------------------------------------
    typedef logic [7:0]  uart_byte_t;   // one serial data byte
    typedef logic [31:0] bus_data_t;    // register bus word

    // receive fifo entry, 9 bits
    typedef struct packed {
        logic       ferr;               // stop bit read as 0
        uart_byte_t data;               // received byte
    } rx_entry_t;

    // register map
    typedef enum logic [1:0] {
        ADDR_CTRL   = 2'd0,
        ADDR_STATUS = 2'd1,
        ADDR_DATA   = 2'd2
    } reg_addr_e;

    localparam int DIV_WIDTH = 16;      // bit-time divisor width

    // control register ------------------------------------------------------
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_CLR_TX_BIT = 1; // self clearing, not stored
    localparam int CTRL_CLR_RX_BIT = 2; // self clearing, also drops overrun
    localparam int CTRL_DIV_LSB    = 16; // divisor in 31:16

    // status register -------------------------------------------------------
    localparam int ST_TX_FREE    = 0;
    localparam int ST_TX_HALF    = 1;
    localparam int ST_RX_AVAIL   = 2;
    localparam int ST_RX_HALF    = 3;
    localparam int ST_TX_BUSY    = 4;
    localparam int ST_RX_OVERRUN = 5;

    // data register read layout, byte in 7:0
    localparam int DATA_FERR_BIT  = 8;
    localparam int DATA_VALID_BIT = 31;

endpackage

// ==== fifo_if.sv ====
//--------------------------------------------------------------------------
// fifo port bundle, one payload type per instance
// producer pushes, consumer pops, the fifo itself sits in between
//--------------------------------------------------------------------------
`timescale 1ns/10ps

interface fifo_if #(
    parameter type payload_t = logic [7:0]  // entry type
) ();
    payload_t wdata;    // push data
    logic     we;       // push strobe
    logic     free;     // room for one more
    logic     re;       // pop strobe
    payload_t rdata;    // head entry, valid with avail
    logic     avail;    // not empty

    modport producer (output wdata, we, input free);
    modport consumer (output re, input rdata, avail);
    modport fifo (input wdata, we, re, output free, rdata, avail);
endinterface

// ==== sync_fifo.sv ====
//--------------------------------------------------------------------------
// single-clock fifo, power-of-two depth, combinational read
// writes when full and reads when empty are ignored
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module sync_fifo #(
    parameter int  DEPTH     = 4,           // power of two, at least 2
    parameter type payload_t = logic [7:0]  // stored entry
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic clear_i,   // sync flush, high active
    output logic half_o,    // level at least DEPTH/2
    fifo_if.fifo f
);
    localparam int AW = $clog2(DEPTH);

    payload_t    mem [DEPTH];   // storage, no reset
    logic [AW:0] wptr;          // msb is the wrap bit
    logic [AW:0] rptr;
    logic [AW:0] level;
    logic        match;
    logic        full;
    logic        empty;
    logic        do_wr;
    logic        do_rd;

    // access guard ----------------------------------------------------------
    assign do_wr = f.we & ~full;    // drop push when full
    assign do_rd = f.re & ~empty;   // drop pop when empty

    // pointers
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wptr <= '0;
            rptr <= '0;
        end else if (clear_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_wr)
                wptr <= wptr + 1'b1;
            if (do_rd)
                rptr <= rptr + 1'b1;
        end
    end

    // flags -----------------------------------------------------------------
    assign match = (wptr[AW-1:0] == rptr[AW-1:0]);
    assign full  = match & (wptr[AW] != rptr[AW]);  // same slot, other lap
    assign empty = match & (wptr[AW] == rptr[AW]);
    assign level = wptr - rptr;
    assign half_o = level[AW-1] | full;              // top half of level

    assign f.free  = ~full;
    assign f.avail = ~empty;

    // storage
    always_ff @(posedge clk_i) begin
        if (do_wr)
            mem[wptr[AW-1:0]] <= f.wdata;
    end

    assign f.rdata = mem[rptr[AW-1:0]];  // head, only meaningful with avail

endmodule

// ==== uart_tx.sv ====
//--------------------------------------------------------------------------
// 8N1 transmitter, pops a byte from the tx fifo and shifts it out lsb first
// bit time is div_i clock cycles
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module uart_tx
    import uart_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 en_i,      // engine enable
    input  logic [DIV_WIDTH-1:0] div_i,     // cycles per bit
    output logic                 txd_o,     // serial out, idle high
    output logic                 busy_o,    // frame in flight
    fifo_if.consumer             q
);
    typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

    tx_state_e            state;
    logic [DIV_WIDTH-1:0] cnt;      // cycles within the current bit
    logic [DIV_WIDTH-1:0] div_last;
    logic [3:0]           bit_cnt;  // 0 start .. 9 stop
    logic [9:0]           shreg;    // {stop, data, start}
    logic                 tick;     // last cycle of a bit

    assign div_last = div_i - 1'b1;
    assign tick     = (cnt == div_last);

    // pop only from idle, next frame right after the stop bit
    assign q.re = en_i & (state == TX_IDLE) & q.avail;

    // frame FSM -------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else if (!en_i) begin
            state <= TX_IDLE;   // disabled, abort frame
            cnt   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (q.re) begin
                        shreg <= {1'b1, q.rdata, 1'b0};
                        state <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (tick) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        shreg   <= {1'b1, shreg[9:1]};  // next bit to lsb
                        if (bit_cnt == 4'd9)
                            state <= TX_IDLE;           // stop bit done
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    assign txd_o  = (state == TX_SHIFT) ? shreg[0] : 1'b1;
    assign busy_o = (state == TX_SHIFT);

endmodule

// ==== uart_rx.sv ====
//--------------------------------------------------------------------------
// 8N1 receiver, samples mid-bit and pushes {ferr, byte} into the rx fifo
// a push that finds the fifo full is lost and sets a sticky overrun
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module uart_rx
    import uart_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 en_i,          // engine enable
    input  logic                 rxd_i,         // serial in, async
    input  logic [DIV_WIDTH-1:0] div_i,         // cycles per bit
    input  logic                 clear_rx_i,    // drops overrun
    output logic                 overrun_o,     // sticky
    fifo_if.producer             q
);
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e            state;
    logic [2:0]           rxd_q;        // two sync stages plus previous
    logic                 rxd_s;        // synchronized line
    logic                 fall;         // start edge
    logic [DIV_WIDTH-1:0] cnt;
    logic [DIV_WIDTH-1:0] div_last;
    logic [DIV_WIDTH-1:0] half_last;
    logic                 tick;         // sample point of data/stop bit
    logic [2:0]           bit_cnt;
    uart_byte_t           shreg;        // lsb arrives first
    rx_entry_t            entry;
    logic                 overrun;

    // synchronizer ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            rxd_q <= '1;    // line idles high
        else
            rxd_q <= {rxd_q[1:0], rxd_i};
    end

    assign rxd_s = rxd_q[1];
    assign fall  = rxd_q[2] & ~rxd_q[1];

    assign div_last  = div_i - 1'b1;
    assign half_last = (div_i >> 1) - 1'b1;   // mid start bit
    assign tick      = (cnt == div_last);

    // frame FSM -------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!en_i) begin
            state <= RX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_cnt <= '0;
                    if (fall)
                        state <= RX_START;
                end
                RX_START: begin
                    if (cnt == half_last) begin
                        cnt   <= '0;
                        state <= rxd_s ? RX_IDLE : RX_DATA;  // high again means glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        cnt   <= '0;
                        state <= RX_IDLE;   // entry pushed this cycle
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data shift, payload only
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && tick)
            shreg <= {rxd_s, shreg[7:1]};
    end

    // push at the stop-bit sample ---------------------------------------------
    assign entry.ferr = ~rxd_s;     // stop bit must be 1
    assign entry.data = shreg;
    assign q.wdata    = entry;
    assign q.we       = en_i & (state == RX_STOP) & tick;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            overrun <= 1'b0;
        else if (clear_rx_i)
            overrun <= 1'b0;
        else if (q.we && !q.free)
            overrun <= 1'b1;    // frame dropped
    end

    assign overrun_o = overrun;

endmodule

// ==== uart_regs.sv ====
//--------------------------------------------------------------------------
// register block, decodes bus strobes into control, fifo push/pop and clears
// read data comes back with ack one cycle after the strobe
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module uart_regs
    import uart_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  reg_addr_e            addr_i,
    input  logic                 we_i,      // write strobe
    input  logic                 re_i,      // read strobe
    input  bus_data_t            wdata_i,
    output bus_data_t            rdata_o,
    output logic                 ack_o,     // read done
    output logic                 en_o,
    output logic [DIV_WIDTH-1:0] div_o,
    output logic                 clr_tx_o,  // one-cycle flush
    output logic                 clr_rx_o,
    input  logic                 tx_half_i,
    input  logic                 rx_half_i,
    input  logic                 tx_busy_i,
    input  logic                 overrun_i,
    fifo_if.producer             txq,
    fifo_if.consumer             rxq
);
    logic                 en_q;
    logic [DIV_WIDTH-1:0] div_q;
    logic                 wr_ctrl;
    rx_entry_t            rx_head;
    bus_data_t            status_w;
    bus_data_t            rd_word;

    assign wr_ctrl = we_i & (addr_i == ADDR_CTRL);

    // control register ------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            en_q  <= 1'b0;
            div_q <= '0;
        end else if (wr_ctrl) begin
            en_q  <= wdata_i[CTRL_EN_BIT];
            div_q <= wdata_i[CTRL_DIV_LSB +: DIV_WIDTH];
        end
    end

    assign en_o     = en_q;
    assign div_o    = div_q;
    assign clr_tx_o = wr_ctrl & wdata_i[CTRL_CLR_TX_BIT];
    assign clr_rx_o = wr_ctrl & wdata_i[CTRL_CLR_RX_BIT];

    // fifo side, same-cycle push and pop
    assign txq.wdata = wdata_i[7:0];
    assign txq.we    = we_i & (addr_i == ADDR_DATA);
    assign rxq.re    = re_i & (addr_i == ADDR_DATA);
    assign rx_head   = rxq.rdata;

    // status word
    always_comb begin
        status_w                = '0;
        status_w[ST_TX_FREE]    = txq.free;
        status_w[ST_TX_HALF]    = tx_half_i;
        status_w[ST_RX_AVAIL]   = rxq.avail;
        status_w[ST_RX_HALF]    = rx_half_i;
        status_w[ST_TX_BUSY]    = tx_busy_i;
        status_w[ST_RX_OVERRUN] = overrun_i;
    end

    // read mux --------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (addr_i)
            ADDR_CTRL: begin
                rd_word[CTRL_DIV_LSB +: DIV_WIDTH] = div_q;
                rd_word[CTRL_EN_BIT]               = en_q;
            end
            ADDR_STATUS: rd_word = status_w;
            ADDR_DATA: begin
                if (rxq.avail) begin    // empty reads as valid = 0
                    rd_word[7:0]           = rx_head.data;
                    rd_word[DATA_FERR_BIT]  = rx_head.ferr;
                    rd_word[DATA_VALID_BIT] = 1'b1;
                end
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            ack_o <= 1'b0;
        else
            ack_o <= re_i;
    end

    always_ff @(posedge clk_i) begin
        if (re_i)
            rdata_o <= rd_word;
    end

endmodule

// ==== uart_top.sv ====
//--------------------------------------------------------------------------
// uart peripheral top, register bus in, serial lines out
// tx path regs -> tx fifo -> uart_tx, rx path uart_rx -> rx fifo -> regs
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module uart_top
    import uart_pkg::*;
#(
    parameter int TX_DEPTH = 4,     // power of two
    parameter int RX_DEPTH = 8
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  reg_addr_e addr_i,
    input  logic      we_i,
    input  logic      re_i,
    input  bus_data_t wdata_i,
    output bus_data_t rdata_o,
    output logic      ack_o,
    input  logic      rxd_i,
    output logic      txd_o
);
    logic                 en;
    logic [DIV_WIDTH-1:0] div;
    logic                 clr_tx;
    logic                 clr_rx;
    logic                 tx_half;
    logic                 rx_half;
    logic                 tx_busy;
    logic                 overrun;

    fifo_if #(.payload_t(uart_byte_t)) tx_fifo_if ();
    fifo_if #(.payload_t(rx_entry_t))  rx_fifo_if ();

    uart_regs uart_regs_inst (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .addr_i    (addr_i),
        .we_i      (we_i),
        .re_i      (re_i),
        .wdata_i   (wdata_i),
        .rdata_o   (rdata_o),
        .ack_o     (ack_o),
        .en_o      (en),
        .div_o     (div),
        .clr_tx_o  (clr_tx),
        .clr_rx_o  (clr_rx),
        .tx_half_i (tx_half),
        .rx_half_i (rx_half),
        .tx_busy_i (tx_busy),
        .overrun_i (overrun),
        .txq       (tx_fifo_if.producer),
        .rxq       (rx_fifo_if.consumer)
    );

    // transmit path ---------------------------------------------------------
    sync_fifo #(.DEPTH(TX_DEPTH), .payload_t(uart_byte_t)) tx_fifo_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clear_i (clr_tx),
        .half_o  (tx_half),
        .f       (tx_fifo_if.fifo)
    );

    uart_tx uart_tx_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en),
        .div_i  (div),
        .txd_o  (txd_o),
        .busy_o (tx_busy),
        .q      (tx_fifo_if.consumer)
    );

    // receive path ----------------------------------------------------------
    uart_rx uart_rx_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (en),
        .rxd_i      (rxd_i),
        .div_i      (div),
        .clear_rx_i (clr_rx),
        .overrun_o  (overrun),
        .q          (rx_fifo_if.producer)
    );

    sync_fifo #(.DEPTH(RX_DEPTH), .payload_t(rx_entry_t)) rx_fifo_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .clear_i (clr_rx),
        .half_o  (rx_half),
        .f       (rx_fifo_if.fifo)
    );

endmodule

// ==== tb_uart.sv ====
//--------------------------------------------------------------------------
// testbench for the uart peripheral with random bytes through the register bus
// loopback and direct line frames checked against a queue model
//--------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_uart
    import uart_pkg::*;
();
    localparam int TX_DEPTH   = 4;      // uart_top defaults
    localparam int RX_DEPTH   = 8;
    localparam int ACK_LIMIT  = 8;      // cycles for a read ack
    localparam int POLL_LIMIT = 1000;   // status/data polls

    logic      clk_i;
    logic      rstn_i;
    reg_addr_e addr_i;
    logic      we_i;
    logic      re_i;
    bus_data_t wdata_i;
    bus_data_t rdata_o;
    logic      ack_o;
    logic      rxd_i;
    logic      txd_o;
    logic      loop_en;     // txd_o back into rxd_i
    logic      line_drv;    // rxd_i when the loop is open

    rx_entry_t            model_q[$];   // expected receive entries
    logic                 model_ovr;    // expected sticky overrun
    logic [DIV_WIDTH-1:0] div;          // current bit time
    int                   seed;

    assign rxd_i = loop_en ? txd_o : line_drv;

    uart_top uart_top_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .addr_i  (addr_i),
        .we_i    (we_i),
        .re_i    (re_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .ack_o   (ack_o),
        .rxd_i   (rxd_i),
        .txd_o   (txd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;    // 20 ns period
    end

    // error handling and compares -------------------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s exp %h got %h", name, exp, got));
    endtask

    task automatic check_status(input bus_data_t exp, input bus_data_t mask,
                                input bus_data_t got);
        if ((got & mask) !== (exp & mask))
            stop_on_error($sformatf("FAILED status exp %h got %h", exp & mask, got & mask));
    endtask

    task automatic check_entry(input rx_entry_t exp, input logic exp_valid,
                               input bus_data_t got);
        rx_entry_t got_e;
        got_e.data = got[7:0];
        got_e.ferr = got[DATA_FERR_BIT];
        if (got[DATA_VALID_BIT] !== exp_valid)
            stop_on_error($sformatf("FAILED data_valid exp %h got %h",
                                    exp_valid, got[DATA_VALID_BIT]));
        if (exp_valid && got_e !== exp)
            stop_on_error($sformatf("FAILED rx_entry exp %h got %h", exp, got_e));
    endtask

    // bus access with strobes on the falling edge ---------------------------
    task automatic bus_write(input reg_addr_e addr, input bus_data_t data);
        @(negedge clk_i);
        addr_i  = addr;
        wdata_i = data;
        we_i    = 1'b1;
        @(negedge clk_i);
        we_i = 1'b0;        // single-cycle strobe
    endtask

    task automatic bus_read(input reg_addr_e addr, output bus_data_t data);
        int n;
        @(negedge clk_i);
        check_bit("ack_o", 1'b0, ack_o);    // low between reads
        addr_i = addr;
        re_i   = 1'b1;
        @(negedge clk_i);
        re_i = 1'b0;
        n    = 0;
        while (ack_o !== 1'b1) begin
            if (n == ACK_LIMIT)
                stop_on_error("read strobe got no ack");
            @(negedge clk_i);
            n++;
        end
        data = rdata_o;     // registered with ack
    endtask

    function automatic bus_data_t ctrl_word(input logic clr_rx);
        bus_data_t w;
        w                            = '0;
        w[CTRL_DIV_LSB +: DIV_WIDTH] = div;
        w[CTRL_EN_BIT]               = 1'b1;
        w[CTRL_CLR_RX_BIT]           = clr_rx;
        return w;
    endfunction

    // reference model ---------------------------------------------------------
    task automatic model_rx_push(input logic ferr, input uart_byte_t b);
        rx_entry_t e;
        e.ferr = ferr;
        e.data = b;
        if (model_q.size() < RX_DEPTH)
            model_q.push_back(e);
        else
            model_ovr = 1'b1;   // fifo full so the frame is lost
    endtask

    // full status word while the transmitter sits idle
    function automatic bus_data_t model_status();
        bus_data_t s;
        s                = '0;
        s[ST_TX_FREE]    = 1'b1;
        s[ST_RX_AVAIL]   = (model_q.size() > 0);
        s[ST_RX_HALF]    = (model_q.size() >= RX_DEPTH / 2);
        s[ST_RX_OVERRUN] = model_ovr;
        return s;
    endfunction

    // poll DATA until an entry shows up and compare it with the model head
    task automatic expect_entry();
        bus_data_t w;
        int        n;
        n = 0;
        bus_read(ADDR_DATA, w);
        while (!w[DATA_VALID_BIT]) begin
            if (n == POLL_LIMIT)
                stop_on_error("no receive entry arrived in time");
            bus_read(ADDR_DATA, w);
            n++;
        end
        if (model_q.size() == 0)
            stop_on_error("receive entry that the model did not predict");
        check_entry(model_q.pop_front(), 1'b1, w);
    endtask

    task automatic wait_tx_idle();
        bus_data_t w;
        int        n;
        n = 0;
        bus_read(ADDR_STATUS, w);
        while (w[ST_TX_BUSY]) begin
            if (n == POLL_LIMIT)
                stop_on_error("transmitter stayed busy");
            bus_read(ADDR_STATUS, w);
            n++;
        end
    endtask

    // one 8N1 frame on rxd_i with div cycles per bit and a short idle gap after
    task automatic send_frame(input uart_byte_t b, input logic stop);
        logic [9:0] bits;
        int         i;
        bits = {stop, b, 1'b0};     // lsb first
        for (i = 0; i < 10; i++) begin
            @(negedge clk_i);
            line_drv = bits[i];
            repeat (int'(div) - 1) @(negedge clk_i);
        end
        @(negedge clk_i);
        line_drv = 1'b1;
        repeat (4) @(negedge clk_i);
    endtask

    // test sequence -----------------------------------------------------------
    initial begin
        bus_data_t  w;
        bus_data_t  exp_w;
        bus_data_t  mask;
        uart_byte_t b;
        int         nb;
        int         k;
        seed      = $urandom(32'h205acefc);
        rstn_i    = 1'b0;
        addr_i    = ADDR_CTRL;
        we_i      = 1'b0;
        re_i      = 1'b0;
        wdata_i   = '0;
        loop_en   = 1'b0;
        line_drv  = 1'b1;
        model_ovr = 1'b0;
        div       = '0;
        repeat (10) @(negedge clk_i);
        rstn_i = 1'b1;

        // idle after reset
        check_bit("txd_o", 1'b1, txd_o);
        bus_read(ADDR_STATUS, w);
        check_status(model_status(), '1, w);
        bus_read(ADDR_DATA, w);
        check_entry(rx_entry_t'('0), 1'b0, w);

        // loopback bursts each drained before the next
        div     = DIV_WIDTH'(8 + $urandom % 25);
        loop_en = 1'b1;
        bus_write(ADDR_CTRL, ctrl_word(1'b0));
        for (k = 0; k < 6; k++) begin
            nb = 1 + int'($urandom % TX_DEPTH);
            repeat (nb) begin
                b = uart_byte_t'($urandom);
                bus_write(ADDR_DATA, {24'h0, b});
                model_rx_push(1'b0, b);
            end
            repeat (nb) expect_entry();
        end
        wait_tx_idle();
        bus_read(ADDR_STATUS, w);
        check_status(model_status(), '1, w);

        // overfill tx so one byte in flight plus a full fifo survive
        for (k = 0; k < TX_DEPTH + 3; k++) begin
            b = uart_byte_t'($urandom);
            bus_write(ADDR_DATA, {24'h0, b});
            if (k <= TX_DEPTH)
                model_rx_push(1'b0, b);
        end
        exp_w             = '0;
        exp_w[ST_TX_HALF] = 1'b1;
        exp_w[ST_TX_BUSY] = 1'b1;
        mask              = exp_w;
        mask[ST_TX_FREE]  = 1'b1;   // free must read 0
        bus_read(ADDR_STATUS, w);
        check_status(exp_w, mask, w);
        repeat (TX_DEPTH + 1) expect_entry();
        wait_tx_idle();
        bus_read(ADDR_DATA, w);
        check_entry(rx_entry_t'('0), 1'b0, w);

        // open loop and overflow the rx fifo with direct frames
        loop_en = 1'b0;
        for (k = 0; k < RX_DEPTH + 2; k++) begin
            b = uart_byte_t'($urandom);
            send_frame(b, 1'b1);
            model_rx_push(1'b0, b);
            bus_read(ADDR_STATUS, w);
            check_status(model_status(), '1, w);    // half and overrun per level
        end
        repeat (RX_DEPTH) expect_entry();
        bus_read(ADDR_DATA, w);
        check_entry(rx_entry_t'('0), 1'b0, w);

        // stop bit 0 gives a frame error
        b = uart_byte_t'($urandom);
        send_frame(b, 1'b0);
        model_rx_push(1'b1, b);
        expect_entry();

        // clear rx fifo and overrun
        for (k = 0; k < 2; k++) begin
            b = uart_byte_t'($urandom);
            send_frame(b, 1'b1);
            model_rx_push(1'b0, b);
        end
        bus_read(ADDR_STATUS, w);
        check_status(model_status(), '1, w);
        bus_write(ADDR_CTRL, ctrl_word(1'b1));
        model_q.delete();
        model_ovr = 1'b0;
        bus_read(ADDR_STATUS, w);
        check_status(model_status(), '1, w);
        bus_read(ADDR_DATA, w);
        check_entry(rx_entry_t'('0), 1'b0, w);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== list.f ====
uart_pkg.sv
fifo_if.sv
sync_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_uart.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the uart testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_uart -f list.f -o tb_uart_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_uart_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0
